// ==== compile.f ====
source/icache_pkg.sv
source/icache_fetcher.sv
source/icache_blocks.sv
source/icache_memctrl.sv
source/icache.sv
bench/icache_mem_model.sv
bench/icache_tb.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the instruction cache testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module icache_tb -Mdir obj_dir -f compile.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vicache_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation finished"
exit 0

// ==== bench/icache_tb.sv ====
// Instruction cache testbench

`timescale 1ns/10ps

module icache_tb;

    localparam logic [15:0] SEED = 16'd23644;
    localparam int REQ_COUNT = 300;
    localparam int ERR_BIT = 20;
    // Second tag for the same index
    localparam int TAG_SEL_BIT = 12;
    localparam logic [31:0] BASE_ADDR = 32'h0001_0000;
    localparam logic [31:0] DATA_KEY = 32'h5A5A_0000;
    // 300 requests at 40 cycles each plus margin
    localparam int unsigned TIMEOUT = 13000;

    logic aclk = 1'b0;
    logic arst_n;
    logic flush_req;
    logic flush_ack;
    logic ctrl_arvalid;
    logic ctrl_arready;
    logic [icache_pkg::ADDR_W-1:0] ctrl_araddr;
    logic [icache_pkg::ID_W-1:0] ctrl_arid;
    logic ctrl_rvalid;
    logic ctrl_rready;
    logic [icache_pkg::ID_W-1:0] ctrl_rid;
    logic [1:0] ctrl_rresp;
    logic [icache_pkg::ILEN-1:0] ctrl_rdata;
    logic mem_arvalid;
    logic mem_arready;
    logic [icache_pkg::ADDR_W-1:0] mem_araddr;
    logic mem_rvalid;
    logic mem_rready;
    logic [icache_pkg::MEM_DATA_W-1:0] mem_rdata;
    logic [1:0] mem_rresp;
    logic mem_rlast;
    logic [1:0] rnd_bits;
    // Keeps ctrl_rready low while a flush waits on the response
    logic rready_hold;

    // Reference model of the line store
    logic [15:0] lfsr;
    int unsigned cycle_cnt = 0;
    logic [icache_pkg::DEPTH-1:0] model_valid;
    logic [icache_pkg::TAG_W-1:0] model_tag [icache_pkg::DEPTH];
    logic req_open;
    logic pend_hit;
    logic [icache_pkg::ADDR_W-1:0] pend_addr;
    logic [icache_pkg::ID_W-1:0] pend_id;
    int unsigned ar_seen;
    logic [icache_pkg::ADDR_W-1:0] ar_line;
    logic [icache_pkg::INDEX_W-1:0] in_index;
    logic [icache_pkg::INDEX_W-1:0] pend_index;
    logic hit_expected;
    logic [icache_pkg::ILEN-1:0] exp_word;
    logic [icache_pkg::ADDR_W-1:0] exp_line;

    always #5 aclk = ~aclk;

    icache u_icache (.*);

    icache_mem_model #(.ERR_BIT(ERR_BIT), .DATA_KEY(DATA_KEY)) u_mem (.*);

    ////////////////////////////////////////////////////////////
    // Failure reporting
    ////////////////////////////////////////////////////////////

    task automatic stop_run();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("FAILED at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, want);
        stop_run();
    endtask

    task automatic report_problem(input string what);
        $display("Error at %0t: %s", $time, what);
        stop_run();
    endtask

    ////////////////////////////////////////////////////////////
    // Reference tracking
    ////////////////////////////////////////////////////////////

    assign in_index = ctrl_araddr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
    assign pend_index = pend_addr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
    assign hit_expected = model_valid[in_index]
        && (model_tag[in_index] == ctrl_araddr[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W]);
    // Memory word rule and line-aligned refill address
    assign exp_word = {pend_addr[icache_pkg::ADDR_W-1:2], 2'b00} ^ DATA_KEY;
    assign exp_line = {pend_addr[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W],
                       {icache_pkg::OFFSET_W{1'b0}}};

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            req_open <= 1'b0;
            pend_hit <= 1'b0;
            ar_seen <= 0;
            model_valid <= '0;
        end else begin
            if (ctrl_arvalid && ctrl_arready) begin
                req_open <= 1'b1;
                pend_addr <= ctrl_araddr;
                pend_id <= ctrl_arid;
                pend_hit <= hit_expected;
                ar_seen <= 0;
            end
            if (mem_arvalid && mem_arready) begin
                ar_seen <= ar_seen + 1;
                ar_line <= mem_araddr;
            end
            // Good refill lands in the model once answered
            if (ctrl_rvalid && ctrl_rready) begin
                req_open <= 1'b0;
                if (!pend_hit && !pend_addr[ERR_BIT]) begin
                    model_valid[pend_index] <= 1'b1;
                    model_tag[pend_index] <= pend_addr[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
                end
            end
            if (flush_ack) begin
                model_valid <= '0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    rid_check: assert property (@(posedge aclk) disable iff (!arst_n)
        ctrl_rvalid |-> ctrl_rid == pend_id)
        else report_mismatch("ctrl_rid", 32'($sampled(ctrl_rid)), 32'($sampled(pend_id)));
    data_check: assert property (@(posedge aclk) disable iff (!arst_n)
        ctrl_rvalid && !pend_addr[ERR_BIT] |-> ctrl_rdata == exp_word)
        else report_mismatch("ctrl_rdata", $sampled(ctrl_rdata), $sampled(exp_word));
    okay_check: assert property (@(posedge aclk) disable iff (!arst_n)
        ctrl_rvalid && !pend_addr[ERR_BIT] |-> ctrl_rresp == icache_pkg::RESP_OKAY)
        else report_mismatch("ctrl_rresp", 32'($sampled(ctrl_rresp)), 32'(icache_pkg::RESP_OKAY));
    // Error region
    slverr_check: assert property (@(posedge aclk) disable iff (!arst_n)
        ctrl_rvalid && pend_addr[ERR_BIT] |-> ctrl_rresp == icache_pkg::RESP_SLVERR)
        else report_mismatch("ctrl_rresp", 32'($sampled(ctrl_rresp)),
                             32'(icache_pkg::RESP_SLVERR));
    zero_check: assert property (@(posedge aclk) disable iff (!arst_n)
        ctrl_rvalid && pend_addr[ERR_BIT] |-> ctrl_rdata == '0)
        else report_mismatch("ctrl_rdata", $sampled(ctrl_rdata), 32'd0);
    hit_latency: assert property (@(posedge aclk) disable iff (!arst_n)
        ctrl_arvalid && ctrl_arready && hit_expected |=> !ctrl_rvalid ##1 ctrl_rvalid)
        else report_problem("hit response did not come 2 cycles after acceptance");
    // One burst per miss, none per hit
    refill_count: assert property (@(posedge aclk) disable iff (!arst_n)
        ctrl_rvalid && ctrl_rready |-> ar_seen == (pend_hit ? 0 : 1))
        else report_mismatch("mem_ar handshakes", $sampled(ar_seen),
                             $sampled(pend_hit) ? 32'd0 : 32'd1);
    refill_addr: assert property (@(posedge aclk) disable iff (!arst_n)
        ctrl_rvalid && ctrl_rready && !pend_hit |-> ar_line == exp_line)
        else report_mismatch("mem_araddr", $sampled(ar_line), $sampled(exp_line));
    hold_check: assert property (@(posedge aclk) disable iff (!arst_n)
        ctrl_rvalid && !ctrl_rready |=> ctrl_rvalid && $stable(ctrl_rdata)
            && $stable(ctrl_rid) && $stable(ctrl_rresp))
        else report_problem("response changed while ctrl_rready was low");
    busy_check: assert property (@(posedge aclk) disable iff (!arst_n)
        ctrl_rvalid |-> !ctrl_arready)
        else report_problem("ctrl_arready high while a response was pending");
    flush_check: assert property (@(posedge aclk) disable iff (!arst_n)
        flush_ack |-> !req_open)
        else report_problem("flush_ack high while a request was pending");
    // Quiet outputs in reset and on the first edge after it
    reset_check: assert property (@(posedge aclk)
        !arst_n || $rose(arst_n) |-> !ctrl_arready && !ctrl_rvalid && !mem_arvalid
            && !mem_rready && !flush_ack)
        else report_problem("handshake output high during reset");

    always @(posedge aclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT) begin
            report_problem("timeout before all requests were answered");
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 16'hB400 : 16'h0000);
        end
        return v;
    endfunction

    // Eight indices, two tags each, error region one time in eight
    function automatic logic [icache_pkg::ADDR_W-1:0] pick_addr();
        logic [icache_pkg::ADDR_W-1:0] a;
        a = BASE_ADDR;
        a[3:2] = 2'(draw_bits(2));
        a[icache_pkg::OFFSET_W +: 3] = 3'(draw_bits(3));
        a[TAG_SEL_BIT] = draw_bits(1) != 0;
        a[ERR_BIT] = draw_bits(3) == 32'd7;
        return a;
    endfunction

    // One edge, fresh stalls for both ready sides
    task automatic tick();
        @(posedge aclk);
        if (rready_hold) begin
            ctrl_rready <= 1'b0;
        end else begin
            ctrl_rready <= draw_bits(2) != 0;
        end
        rnd_bits <= 2'(draw_bits(2));
    endtask

    initial begin
        logic flush_now;
        lfsr = SEED;
        rready_hold = 1'b0;
        arst_n = 1'b0;
        flush_req = 1'b0;
        ctrl_arvalid = 1'b0;
        ctrl_araddr = '0;
        ctrl_arid = '0;
        ctrl_rready = 1'b0;
        rnd_bits = 2'b00;
        repeat (2) tick();
        arst_n <= 1'b1;
        for (int n = 0; n < REQ_COUNT; n++) begin
            tick();
            ctrl_arvalid <= 1'b1;
            ctrl_araddr <= pick_addr();
            ctrl_arid <= icache_pkg::ID_W'(draw_bits(icache_pkg::ID_W));
            do tick(); while (!ctrl_arready);
            ctrl_arvalid <= 1'b0;
            // Occasional flush, raised while the response is still held back
            flush_now = draw_bits(4) == 32'd0;
            rready_hold = flush_now;
            if (flush_now) begin
                do tick(); while (!ctrl_rvalid);
                flush_req <= 1'b1;
                repeat (3) tick();
                rready_hold = 1'b0;
            end
            do tick(); while (!(ctrl_rvalid && ctrl_rready));
            if (flush_now) begin
                do tick(); while (!flush_ack);
                flush_req <= 1'b0;
            end
        end
        repeat (4) tick();
        $display("Test OK");
        $finish;
    end

endmodule

// ==== bench/icache_mem_model.sv ====
// Line refill memory responder

`timescale 1ns/10ps

module icache_mem_model #(
    parameter int ERR_BIT = 20,
    parameter logic [31:0] DATA_KEY = 32'h5A5A_0000
) (
    input  logic                              aclk,
    input  logic                              arst_n,
    // Random stall bits, fresh every cycle
    input  logic [1:0]                        rnd_bits,
    input  logic                              mem_arvalid,
    output logic                              mem_arready,
    input  logic [icache_pkg::ADDR_W-1:0]     mem_araddr,
    output logic                              mem_rvalid,
    input  logic                              mem_rready,
    output logic [icache_pkg::MEM_DATA_W-1:0] mem_rdata,
    output logic [1:0]                        mem_rresp,
    output logic                              mem_rlast
);

    logic busy;
    logic [icache_pkg::ADDR_W-1:0] base_q;
    // Beats already handed over, and the count after this edge
    logic [$clog2(icache_pkg::BEATS):0] sent;
    logic [$clog2(icache_pkg::BEATS):0] next_sent;
    logic [icache_pkg::ADDR_W-1:0] beat_addr;

    assign next_sent = (mem_rvalid && mem_rready) ? sent + 1'b1 : sent;
    assign beat_addr = base_q + icache_pkg::ADDR_W'({next_sent, 2'b00});

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            base_q <= '0;
            sent <= '0;
            mem_arready <= 1'b0;
            mem_rvalid <= 1'b0;
            mem_rlast <= 1'b0;
            mem_rdata <= '0;
            mem_rresp <= icache_pkg::RESP_OKAY;
        end else if (!busy) begin
            if (mem_arvalid && mem_arready) begin
                busy <= 1'b1;
                base_q <= mem_araddr;
                sent <= '0;
                mem_arready <= 1'b0;
            end else begin
                // Address taken one cycle in two
                mem_arready <= rnd_bits[0];
            end
        end else begin
            sent <= next_sent;
            if (next_sent == icache_pkg::BEATS) begin
                busy <= 1'b0;
                mem_rvalid <= 1'b0;
                mem_rlast <= 1'b0;
            end else if (!mem_rvalid || mem_rready) begin
                // Next beat offered three cycles in four
                mem_rvalid <= rnd_bits != 2'b00;
                mem_rlast <= next_sent == icache_pkg::BEATS - 1;
                mem_rdata <= beat_addr ^ DATA_KEY;
                // Whole error region answers SLVERR on every beat
                mem_rresp <= base_q[ERR_BIT] ? icache_pkg::RESP_SLVERR : icache_pkg::RESP_OKAY;
            end
        end
    end

endmodule

// ==== source/icache.sv ====
// Direct-mapped instruction cache top

`timescale 1ns/10ps

module icache (
    input  logic                              aclk,
    input  logic                              arst_n,
    input  logic                              flush_req,
    output logic                              flush_ack,
    input  logic                              ctrl_arvalid,
    output logic                              ctrl_arready,
    input  logic [icache_pkg::ADDR_W-1:0]     ctrl_araddr,
    input  logic [icache_pkg::ID_W-1:0]       ctrl_arid,
    output logic                              ctrl_rvalid,
    input  logic                              ctrl_rready,
    output logic [icache_pkg::ID_W-1:0]       ctrl_rid,
    output logic [1:0]                        ctrl_rresp,
    output logic [icache_pkg::ILEN-1:0]       ctrl_rdata,
    output logic                              mem_arvalid,
    input  logic                              mem_arready,
    output logic [icache_pkg::ADDR_W-1:0]     mem_araddr,
    input  logic                              mem_rvalid,
    output logic                              mem_rready,
    input  logic [icache_pkg::MEM_DATA_W-1:0] mem_rdata,
    input  logic [1:0]                        mem_rresp,
    input  logic                              mem_rlast
);

    // Lookup path
    logic lookup_en;
    logic [icache_pkg::ADDR_W-1:0] lookup_addr;
    logic hit;
    logic miss;
    logic [icache_pkg::ILEN-1:0] lookup_data;
    // Refill request path
    logic refill_valid;
    logic refill_ready;
    logic [icache_pkg::ADDR_W-1:0] refill_addr;
    logic refill_done;
    logic refill_err;
    // Line write and flush into the store
    logic line_wen;
    logic [icache_pkg::ADDR_W-1:0] line_addr;
    logic [icache_pkg::BLOCK_W-1:0] line_data;
    logic cache_flush;
    logic fetch_flush_ack;
    logic mem_flush_ack;

    icache_fetcher u_fetcher (
        .aclk            (aclk),
        .arst_n          (arst_n),
        .flush_req       (flush_req),
        .fetch_flush_ack (fetch_flush_ack),
        .ctrl_arvalid    (ctrl_arvalid),
        .ctrl_arready    (ctrl_arready),
        .ctrl_araddr     (ctrl_araddr),
        .ctrl_arid       (ctrl_arid),
        .ctrl_rvalid     (ctrl_rvalid),
        .ctrl_rready     (ctrl_rready),
        .ctrl_rid        (ctrl_rid),
        .ctrl_rresp      (ctrl_rresp),
        .ctrl_rdata      (ctrl_rdata),
        .lookup_en       (lookup_en),
        .lookup_addr     (lookup_addr),
        .hit             (hit),
        .miss            (miss),
        .lookup_data     (lookup_data),
        .refill_valid    (refill_valid),
        .refill_ready    (refill_ready),
        .refill_addr     (refill_addr),
        .refill_done     (refill_done),
        .refill_err      (refill_err)
    );

    icache_blocks u_blocks (
        .aclk        (aclk),
        .arst_n      (arst_n),
        .cache_flush (cache_flush),
        .line_wen    (line_wen),
        .line_addr   (line_addr),
        .line_data   (line_data),
        .lookup_en   (lookup_en),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .miss        (miss),
        .lookup_data (lookup_data)
    );

    icache_memctrl u_memctrl (
        .aclk          (aclk),
        .arst_n        (arst_n),
        .flush_req     (flush_req),
        .mem_flush_ack (mem_flush_ack),
        .cache_flush   (cache_flush),
        .refill_valid  (refill_valid),
        .refill_ready  (refill_ready),
        .refill_addr   (refill_addr),
        .refill_done   (refill_done),
        .refill_err    (refill_err),
        .mem_arvalid   (mem_arvalid),
        .mem_arready   (mem_arready),
        .mem_araddr    (mem_araddr),
        .mem_rvalid    (mem_rvalid),
        .mem_rready    (mem_rready),
        .mem_rdata     (mem_rdata),
        .mem_rresp     (mem_rresp),
        .mem_rlast     (mem_rlast),
        .line_wen      (line_wen),
        .line_addr     (line_addr),
        .line_data     (line_data)
    );

    // Flush done only once both stages are quiet
    assign flush_ack = fetch_flush_ack & mem_flush_ack;

endmodule

// ==== source/icache_memctrl.sv ====
// Instruction cache refill stage

`timescale 1ns/10ps

module icache_memctrl (
    input  logic                              aclk,
    input  logic                              arst_n,
    input  logic                              flush_req,
    output logic                              mem_flush_ack,
    output logic                              cache_flush,
    input  logic                              refill_valid,
    output logic                              refill_ready,
    input  logic [icache_pkg::ADDR_W-1:0]     refill_addr,
    output logic                              refill_done,
    output logic                              refill_err,
    output logic                              mem_arvalid,
    input  logic                              mem_arready,
    output logic [icache_pkg::ADDR_W-1:0]     mem_araddr,
    input  logic                              mem_rvalid,
    output logic                              mem_rready,
    input  logic [icache_pkg::MEM_DATA_W-1:0] mem_rdata,
    input  logic [1:0]                        mem_rresp,
    input  logic                              mem_rlast,
    output logic                              line_wen,
    output logic [icache_pkg::ADDR_W-1:0]     line_addr,
    output logic [icache_pkg::BLOCK_W-1:0]    line_data
);

    icache_pkg::mem_state_e state;
    logic [$clog2(icache_pkg::BEATS)-1:0] beat_cnt;
    // Sticky error over the burst
    logic err_q;
    logic beat_err;
    logic take_refill;
    logic [icache_pkg::BLOCK_W-1:0] line_q;

    // Flush wins over a refill in idle
    assign refill_ready = (state == icache_pkg::MEM_IDLE) & ~flush_req;
    assign take_refill = refill_valid & refill_ready;
    assign beat_err = mem_rresp != icache_pkg::RESP_OKAY;

    // Line goes back to the address it was read from
    assign line_addr = mem_araddr;
    assign line_data = line_q;

    ////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state <= icache_pkg::MEM_IDLE;
            mem_arvalid <= 1'b0;
            mem_rready <= 1'b0;
            beat_cnt <= '0;
            err_q <= 1'b0;
            refill_done <= 1'b0;
            refill_err <= 1'b0;
            line_wen <= 1'b0;
            cache_flush <= 1'b0;
            mem_flush_ack <= 1'b0;
        end else begin
            // Single cycle pulses
            refill_done <= 1'b0;
            line_wen <= 1'b0;
            cache_flush <= 1'b0;
            case (state)
                icache_pkg::MEM_IDLE: begin
                    if (flush_req) begin
                        cache_flush <= 1'b1;
                        state <= icache_pkg::MEM_FLUSH;
                    end else if (take_refill) begin
                        mem_arvalid <= 1'b1;
                        beat_cnt <= '0;
                        err_q <= 1'b0;
                        state <= icache_pkg::MEM_ADDR;
                    end
                end
                icache_pkg::MEM_ADDR: begin
                    if (mem_arready) begin
                        mem_arvalid <= 1'b0;
                        mem_rready <= 1'b1;
                        state <= icache_pkg::MEM_DATA;
                    end
                end
                // rready stays up, every valid beat is taken
                icache_pkg::MEM_DATA: begin
                    if (mem_rvalid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        err_q <= err_q | beat_err;
                        if (mem_rlast) begin
                            mem_rready <= 1'b0;
                            refill_done <= 1'b1;
                            refill_err <= err_q | beat_err;
                            line_wen <= ~(err_q | beat_err);
                            state <= icache_pkg::MEM_IDLE;
                        end
                    end
                end
                // Ack one cycle after the clear, held with the request
                icache_pkg::MEM_FLUSH: begin
                    mem_flush_ack <= flush_req;
                    if (!flush_req) begin
                        state <= icache_pkg::MEM_IDLE;
                    end
                end
                default: state <= icache_pkg::MEM_IDLE;
            endcase
        end
    end

    // Aligned address and beat assembly, first beat ends in the low word
    always_ff @(posedge aclk) begin
        if (take_refill) begin
            mem_araddr <= {refill_addr[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W],
                           {icache_pkg::OFFSET_W{1'b0}}};
        end
        if (state == icache_pkg::MEM_DATA && mem_rvalid) begin
            line_q <= {mem_rdata, line_q[icache_pkg::BLOCK_W-1:icache_pkg::MEM_DATA_W]};
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    assert property (@(posedge aclk) disable iff (!arst_n)
        mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr));

    // Burst length agrees with the memory side
    assert property (@(posedge aclk) disable iff (!arst_n)
        mem_rvalid && mem_rready |-> mem_rlast == (beat_cnt == icache_pkg::BEATS - 1));

endmodule

// ==== source/icache_blocks.sv ====
// Instruction cache line store

`timescale 1ns/10ps

module icache_blocks (
    input  logic                           aclk,
    input  logic                           arst_n,
    input  logic                           cache_flush,
    input  logic                           line_wen,
    input  logic [icache_pkg::ADDR_W-1:0]  line_addr,
    input  logic [icache_pkg::BLOCK_W-1:0] line_data,
    input  logic                           lookup_en,
    input  logic [icache_pkg::ADDR_W-1:0]  lookup_addr,
    output logic                           hit,
    output logic                           miss,
    output logic [icache_pkg::ILEN-1:0]    lookup_data
);

    // Data, tag and valid arrays
    logic [icache_pkg::BLOCK_W-1:0] data_mem [icache_pkg::DEPTH];
    logic [icache_pkg::TAG_W-1:0] tag_mem [icache_pkg::DEPTH];
    logic [icache_pkg::DEPTH-1:0] valid_q;

    logic [icache_pkg::INDEX_W-1:0] wr_index;
    logic [icache_pkg::TAG_W-1:0] wr_tag;
    logic [icache_pkg::INDEX_W-1:0] rd_index;
    logic [icache_pkg::TAG_W-1:0] rd_tag;
    // Word inside the line, bits 3:2
    logic [icache_pkg::OFFSET_W-3:0] rd_word;
    logic tag_match;

    ////////////////////////////////////////////////////////////
    // Address split
    ////////////////////////////////////////////////////////////

    assign wr_index = line_addr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
    assign wr_tag = line_addr[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
    assign rd_index = lookup_addr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
    assign rd_tag = lookup_addr[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
    assign rd_word = lookup_addr[icache_pkg::OFFSET_W-1:2];

    assign tag_match = valid_q[rd_index] && (tag_mem[rd_index] == rd_tag);

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////

    // Flush drops every line at once
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (cache_flush) begin
            valid_q <= '0;
        end else if (line_wen) begin
            valid_q[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (line_wen) begin
            data_mem[wr_index] <= line_data;
            tag_mem[wr_index] <= wr_tag;
        end
    end

    ////////////////////////////////////////////////////////////
    // Lookup, one cycle
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            hit <= 1'b0;
            miss <= 1'b0;
        end else begin
            hit <= lookup_en & tag_match;
            miss <= lookup_en & ~tag_match;
        end
    end

    // Word select from the indexed line
    always_ff @(posedge aclk) begin
        if (lookup_en) begin
            lookup_data <= data_mem[rd_index][rd_word * icache_pkg::ILEN +: icache_pkg::ILEN];
        end
    end

    // Refill write and flush come from separate refill states
    assert property (@(posedge aclk) disable iff (!arst_n)
        !(line_wen && cache_flush));

endmodule

// ==== source/icache_fetcher.sv ====
// Instruction cache request stage

`timescale 1ns/10ps

module icache_fetcher (
    input  logic                           aclk,
    input  logic                           arst_n,
    input  logic                           flush_req,
    output logic                           fetch_flush_ack,
    input  logic                           ctrl_arvalid,
    output logic                           ctrl_arready,
    input  logic [icache_pkg::ADDR_W-1:0]  ctrl_araddr,
    input  logic [icache_pkg::ID_W-1:0]    ctrl_arid,
    output logic                           ctrl_rvalid,
    input  logic                           ctrl_rready,
    output logic [icache_pkg::ID_W-1:0]    ctrl_rid,
    output logic [1:0]                     ctrl_rresp,
    output logic [icache_pkg::ILEN-1:0]    ctrl_rdata,
    output logic                           lookup_en,
    output logic [icache_pkg::ADDR_W-1:0]  lookup_addr,
    input  logic                           hit,
    input  logic                           miss,
    input  logic [icache_pkg::ILEN-1:0]    lookup_data,
    output logic                           refill_valid,
    input  logic                           refill_ready,
    output logic [icache_pkg::ADDR_W-1:0]  refill_addr,
    input  logic                           refill_done,
    input  logic                           refill_err
);

    icache_pkg::fetch_state_e state;
    // Held request
    logic [icache_pkg::ADDR_W-1:0] addr_q;
    logic [icache_pkg::ID_W-1:0] id_q;
    // Idle flag, low out of reset until the first edge
    logic idle_q;
    // Line has landed, look it up again next cycle
    logic relookup;
    logic accept;

    ////////////////////////////////////////////////////////////
    // Handshakes and lookup drive
    ////////////////////////////////////////////////////////////

    // One request in flight, none taken while a flush is asked
    assign ctrl_arready = idle_q & ~flush_req;
    assign accept = ctrl_arvalid & ctrl_arready;
    assign fetch_flush_ack = idle_q & flush_req;

    assign ctrl_rid = id_q;
    assign refill_addr = addr_q;

    // First lookup straight from the bus, replay from the held address
    assign lookup_en = accept | ((state == icache_pkg::FETCH_REFILL) & relookup);
    assign lookup_addr = accept ? ctrl_araddr : addr_q;

    ////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state <= icache_pkg::FETCH_IDLE;
            idle_q <= 1'b0;
            relookup <= 1'b0;
            ctrl_rvalid <= 1'b0;
            refill_valid <= 1'b0;
        end else begin
            case (state)
                icache_pkg::FETCH_IDLE: begin
                    idle_q <= 1'b1;
                    if (accept) begin
                        idle_q <= 1'b0;
                        state <= icache_pkg::FETCH_LOOKUP;
                    end
                end
                // Flags from the line store arrive this cycle
                icache_pkg::FETCH_LOOKUP: begin
                    if (hit) begin
                        ctrl_rvalid <= 1'b1;
                        state <= icache_pkg::FETCH_RESP;
                    end else if (miss) begin
                        refill_valid <= 1'b1;
                        state <= icache_pkg::FETCH_REFILL;
                    end
                end
                icache_pkg::FETCH_REFILL: begin
                    if (refill_ready) begin
                        refill_valid <= 1'b0;
                    end
                    if (relookup) begin
                        relookup <= 1'b0;
                        state <= icache_pkg::FETCH_LOOKUP;
                    end else if (refill_done) begin
                        // Failed line is never stored, answer right away
                        if (refill_err) begin
                            ctrl_rvalid <= 1'b1;
                            state <= icache_pkg::FETCH_RESP;
                        end else begin
                            relookup <= 1'b1;
                        end
                    end
                end
                icache_pkg::FETCH_RESP: begin
                    if (ctrl_rready) begin
                        ctrl_rvalid <= 1'b0;
                        idle_q <= 1'b1;
                        state <= icache_pkg::FETCH_IDLE;
                    end
                end
                default: state <= icache_pkg::FETCH_IDLE;
            endcase
        end
    end

    // Request and response payload
    always_ff @(posedge aclk) begin
        if (accept) begin
            addr_q <= ctrl_araddr;
            id_q <= ctrl_arid;
        end
        if (state == icache_pkg::FETCH_LOOKUP && hit) begin
            ctrl_rdata <= lookup_data;
            ctrl_rresp <= icache_pkg::RESP_OKAY;
        end
        if (state == icache_pkg::FETCH_REFILL && !relookup && refill_done && refill_err) begin
            ctrl_rdata <= '0;
            ctrl_rresp <= icache_pkg::RESP_SLVERR;
        end
    end

    // Response holds under back-pressure
    assert property (@(posedge aclk) disable iff (!arst_n)
        ctrl_rvalid && !ctrl_rready |=> ctrl_rvalid && $stable(ctrl_rdata)
            && $stable(ctrl_rid) && $stable(ctrl_rresp));

endmodule

// ==== source/icache_pkg.sv ====
// Instruction cache shared definitions
// Widths, geometry, response codes and FSM states

package icache_pkg;

    ////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////

    // Instruction word, always 32 bits
    localparam int ILEN = 32;
    localparam int ADDR_W = 32;
    localparam int ID_W = 4;
    // One beat on the memory read channel
    localparam int MEM_DATA_W = 32;

    ////////////////////////////////////////////////////////////
    // Cache geometry
    ////////////////////////////////////////////////////////////

    // Line payload and number of lines
    localparam int BLOCK_W = 128;
    localparam int DEPTH = 64;
    // Beats per line refill, also the burst length
    localparam int BEATS = BLOCK_W / MEM_DATA_W;
    localparam int INDEX_W = $clog2(DEPTH);
    // Byte offset inside one line
    localparam int OFFSET_W = $clog2(BLOCK_W / 8);
    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Request stage states
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_LOOKUP,
        FETCH_REFILL,
        FETCH_RESP
    } fetch_state_e;

    // Refill stage states
    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_ADDR,
        MEM_DATA,
        MEM_FLUSH
    } mem_state_e;

endpackage
